//--- files.f
rv_pkg.sv
pipe_reg.sv
fetch_stage.sv
reg_file.sv
decode_stage.sv
execute_stage.sv
writeback_stage.sv
rv_core.sv
rv_core_assert.sv
tb_rv_core.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - rv_pkg.sv
  - pipe_reg.sv
  - fetch_stage.sv
  - reg_file.sv
  - decode_stage.sv
  - execute_stage.sv
  - writeback_stage.sv
  - rv_core.sv
  - target: test
    files:
      - rv_core_assert.sv
      - tb_rv_core.sv

//--- tb_rv_core.sv
`timescale 1ns/1ns

module tb_rv_core;

	import rv_pkg::*;

	typedef struct packed {
		word_t addr;
		word_t data;
	} store_t;

	logic  clk = 1'b0;
	logic  reset;
	word_t instr_addr, instr, data_addr, wdata, rdata;
	logic  data_req, data_we, data_stall;

	word_t  imem [256];
	word_t  dmem [256];
	word_t  prog [$];               // program table
	store_t exp_q [$];              // stores in program order
	word_t  poison_addr = 32'h1f0;  // only skipped code writes here
	string  test_name;
	int     n_seen;
	int     cycles;
	int     stall_cycles;
	logic   stall_en;

	rv_core u_rv_core (
		.clk_i(clk), .reset_i(reset), .instr_addr_o(instr_addr), .instr_i(instr),
		.data_addr_o(data_addr), .data_o(wdata), .data_req_o(data_req),
		.data_we_o(data_we), .data_i(rdata), .data_stall_i(data_stall)
	);

	always #20 clk = ~clk;

	// rv32i encoders, field order from the isa manual
	function automatic word_t r_type(int f7, int rs2, int rs1, int f3, int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opc_op};
	endfunction

	function automatic word_t i_type(int imm, int rs1, int f3, int rd, opcode_e op);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
	endfunction

	function automatic word_t s_type(int imm, int rs2, int rs1); // sw only
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], opc_store};
	endfunction

	function automatic word_t b_type(int imm, int rs2, int rs1, int f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], opc_branch};
	endfunction

	function automatic word_t u_type(int imm, int rd, opcode_e op);
		return {imm[19:0], rd[4:0], op};
	endfunction

	function automatic word_t j_type(int imm, int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], opc_jal};
	endfunction

	task automatic stop_with_failure();
		$display("Done: errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input word_t expected, input word_t actual);
		if (expected !== actual)
		begin
			$display("** Error %s: expected %h, actual %h", name, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic record_store(input word_t addr, input word_t data);
		if (addr == poison_addr)
		begin
			$display("%s: a skipped store reached the data port", test_name);
			stop_with_failure();
		end
		if (n_seen >= exp_q.size())
		begin
			$display("%s: more stores than the program makes", test_name);
			stop_with_failure();
		end
		check_value($sformatf("%s, store %0d address", test_name, n_seen), exp_q[n_seen].addr, addr);
		check_value($sformatf("%s, store %0d data", test_name, n_seen), exp_q[n_seen].data, data);
		n_seen++;
	endtask

	task automatic run_program(input string name, input logic with_stall);
		test_name = name;
		reset <= 1'b0;
		stall_en <= with_stall;
		n_seen = 0;
		for (int i = 0; i < 256; i++)
			dmem[i] = (word_t'(i) * 32'h0101_0101) ^ 32'h5a5a_0000;
		repeat (10) @(posedge clk);
		reset <= 1'b1;
		while (n_seen < exp_q.size())
			@(posedge clk);
		repeat (8) @(posedge clk); // room for a late wrong-path store
		stall_en <= 1'b0;
	endtask

	// synchronous instruction and data memories
	always @(posedge clk)
	begin
		instr <= imem[instr_addr[9:2]];
		if (reset && data_req && !data_stall)
		begin
			if (data_we)
			begin
				record_store(data_addr, wdata);
				dmem[data_addr[9:2]] <= wdata;
			end
			else
				rdata <= dmem[data_addr[9:2]];
		end
	end

	initial
	begin
		void'($urandom(32'ha292_31c2));
		forever
		begin
			@(posedge clk);
			data_stall <= stall_en && ($urandom % 3 == 0); // about one cycle in three
		end
	end

	always @(posedge clk)
	begin
		if (!reset)
		begin
			cycles <= 0;
			stall_cycles <= 0;
		end
		else
		begin
			cycles <= cycles + 1;
			stall_cycles <= stall_cycles + int'(data_stall);
			// hard cap in case the stall never drops
			if (cycles > prog.size() * 4 + stall_cycles + 40 || cycles > 4000)
			begin
				$display("%s: timeout, program not done after %0d cycles", test_name, cycles);
				stop_with_failure();
			end
		end
		if (u_rv_core.u_rv_core_assert.fail_cnt != 0)
		begin
			$display("a bound assertion on the memory ports failed");
			stop_with_failure();
		end
	end

	initial
	begin
		reset = 1'b0;
		data_stall = 1'b0;
		stall_en = 1'b0;
		instr = nop_instr;
		rdata = '0;

		prog.push_back(i_type(5, 0, 0, 1, opc_op_imm));       // addi x1, x0, 5
		prog.push_back(i_type(-3, 0, 0, 2, opc_op_imm));      // addi x2, x0, -3
		prog.push_back(r_type(0, 2, 1, 0, 3));                // add x3, x1, x2
		prog.push_back(s_type(32'h100, 3, 0));                // sw x3
		prog.push_back(i_type(4, 1, 1, 4, opc_op_imm));       // slli x4, x1, 4
		prog.push_back(s_type(32'h104, 4, 0));
		prog.push_back(r_type(0, 1, 2, 2, 5));                // slt x5, x2, x1
		prog.push_back(s_type(32'h108, 5, 0));
		prog.push_back(r_type(0, 2, 1, 3, 6));                // sltu x6, x1, x2
		prog.push_back(i_type(32'h401, 2, 5, 7, opc_op_imm)); // srai x7, x2, 1
		prog.push_back(r_type(0, 6, 7, 4, 8));                // xor x8, x7, x6
		prog.push_back(s_type(32'h10c, 8, 0));
		prog.push_back(u_type(32'h12345, 9, opc_lui));        // lui x9
		prog.push_back(i_type(32'h678, 9, 6, 9, opc_op_imm)); // ori x9, x9, 0x678
		prog.push_back(s_type(32'h110, 9, 0));
		prog.push_back(i_type(32'h110, 0, 2, 10, opc_load));  // lw x10, 0x110(x0)
		prog.push_back(i_type(1, 10, 0, 11, opc_op_imm));     // load-use
		prog.push_back(s_type(32'h114, 11, 0));
		prog.push_back(b_type(8, 1, 1, 0));                   // beq taken
		prog.push_back(s_type(poison_addr, 1, 0));
		prog.push_back(j_type(8, 12));                        // jal x12, +8 at 0x50
		prog.push_back(s_type(poison_addr, 1, 0));
		prog.push_back(s_type(32'h118, 12, 0));
		prog.push_back(i_type(32'h68, 0, 0, 13, opc_op_imm)); // addi x13, x0, 0x68
		prog.push_back(i_type(1, 13, 0, 14, opc_jalr));       // jalr x14, 1(x13) at 0x60
		prog.push_back(s_type(poison_addr, 1, 0));
		prog.push_back(s_type(32'h11c, 14, 0));               // jalr lands here, 0x68
		prog.push_back(i_type(7, 1, 0, 0, opc_op_imm));       // addi x0, x1, 7
		prog.push_back(s_type(32'h120, 0, 0));
		prog.push_back(b_type(8, 2, 1, 4));                   // blt x1, x2 not taken
		prog.push_back(s_type(32'h124, 4, 0));
		prog.push_back(b_type(8, 2, 1, 6));                   // bltu x1, x2 taken
		prog.push_back(s_type(poison_addr, 1, 0));
		prog.push_back(j_type(0, 0));                         // park here

		exp_q.push_back(store_t'{32'h100, 32'h0000_0002}); // 5 + -3
		exp_q.push_back(store_t'{32'h104, 32'h0000_0050}); // 5 << 4
		exp_q.push_back(store_t'{32'h108, 32'h0000_0001}); // -3 < 5 signed
		exp_q.push_back(store_t'{32'h10c, 32'hffff_ffff}); // (-3 >>> 1) ^ 1
		exp_q.push_back(store_t'{32'h110, 32'h1234_5678});
		exp_q.push_back(store_t'{32'h114, 32'h1234_5679}); // loaded word + 1
		exp_q.push_back(store_t'{32'h118, 32'h0000_0054}); // jal link
		exp_q.push_back(store_t'{32'h11c, 32'h0000_0064}); // jalr link
		exp_q.push_back(store_t'{32'h120, 32'h0000_0000}); // x0 kept zero
		exp_q.push_back(store_t'{32'h124, 32'h0000_0050});

		for (int i = 0; i < 256; i++)
			imem[i] = (i < prog.size()) ? prog[i] : nop_instr;

		for (int pass = 0; pass < 2; pass++)
			run_program(pass == 0 ? "no stall" : "random stall", pass == 1);

		if (u_rv_core.u_rv_core_assert.fail_cnt == 0)
		begin
			$display("Done: no errors");
			$finish;
		end
		else
		begin
			$display("a bound assertion on the memory ports failed");
			stop_with_failure();
		end
	end

endmodule

//--- rv_core_assert.sv
`timescale 1ns/1ns

module rv_core_assert (
	input logic          clk_i,
	input logic          reset_i,
	input rv_pkg::word_t instr_addr_i,
	input rv_pkg::word_t data_addr_i,
	input rv_pkg::word_t wdata_i,
	input logic          data_req_i,
	input logic          data_we_i,
	input logic          data_stall_i
);

	int fail_cnt = 0; // polled by the testbench

	task automatic log_violation(input string what);
		$error("%s", what);
		fail_cnt++;
	endtask

	a_we_req: assert property (@(posedge clk_i) disable iff (!reset_i) data_we_i |-> data_req_i)
		else log_violation("write enable without a request");

	// checked one cycle on, the flops settle at the first edge
	a_reset_idle: assert property (@(posedge clk_i) !reset_i |=> !data_req_i)
		else log_violation("data request while in reset");

	a_data_align: assert property (@(posedge clk_i) disable iff (!reset_i)
		data_req_i |-> data_addr_i[1:0] == 2'b00)
		else log_violation("data address not word aligned");

	a_instr_align: assert property (@(posedge clk_i) disable iff (!reset_i)
		instr_addr_i[1:0] == 2'b00)
		else log_violation("instruction address not word aligned");

	a_stall_hold: assert property (@(posedge clk_i) disable iff (!reset_i)
		data_req_i && data_stall_i |=> data_req_i && $stable(data_addr_i)
			&& $stable(data_we_i) && $stable(wdata_i))
		else log_violation("stalled request changed");

endmodule

bind rv_core rv_core_assert u_rv_core_assert (
	.clk_i(clk_i), .reset_i(reset_i), .instr_addr_i(instr_addr_o),
	.data_addr_i(data_addr_o), .wdata_i(data_o), .data_req_i(data_req_o),
	.data_we_i(data_we_o), .data_stall_i(data_stall_i)
);

//--- rv_core.sv
`timescale 1ns/1ns

module rv_core (
	input  logic          clk_i,
	input  logic          reset_i,
	output rv_pkg::word_t instr_addr_o,
	input  rv_pkg::word_t instr_i,
	output rv_pkg::word_t data_addr_o,
	output rv_pkg::word_t data_o,
	output logic          data_req_o,
	output logic          data_we_o,
	input  rv_pkg::word_t data_i,
	input  logic          data_stall_i
);

	import rv_pkg::*;

	if_id_t   if_id_d, if_id_q;
	id_ex_t   id_ex_d, id_ex_q;
	ex_mem_t  ex_mem_d, ex_mem_q;
	mem_wb_t  mem_wb_d, mem_wb_q;
	fwd_t     fwd_mem, fwd_wb;
	reg_idx_t rs1, rs2;
	word_t    rdata1, rdata2;
	logic     load_use_stall;
	logic     branch_taken;
	word_t    branch_target;
	logic     redirect;      // taken branch that may act this cycle
	logic     mem_fresh_q;   // ex/mem advanced at the last edge
	word_t    rdata_q;
	word_t    load_data;

	assign redirect = branch_taken && !data_stall_i;

	fetch_stage u_fetch (
		.clk_i(clk_i), .reset_i(reset_i), .hold_i(load_use_stall || data_stall_i),
		.branch_taken_i(branch_taken), .branch_target_i(branch_target),
		.instr_i(instr_i), .instr_addr_o(instr_addr_o), .if_id_o(if_id_d)
	);

	pipe_reg #(.payload_t(if_id_t), .bubble(if_id_bubble)) u_if_id (
		.clk_i(clk_i), .reset_i(reset_i), .hold_i(load_use_stall || data_stall_i),
		.flush_i(redirect), .d_i(if_id_d), .q_o(if_id_q)
	);

	decode_stage u_decode (
		.if_id_i(if_id_q), .ex_rd_i(id_ex_q.rd), .ex_load_i(id_ex_q.load),
		.rdata1_i(rdata1), .rdata2_i(rdata2), .rs1_o(rs1), .rs2_o(rs2),
		.load_use_stall_o(load_use_stall), .id_ex_o(id_ex_d)
	);

	reg_file u_reg_file (
		.clk_i(clk_i), .reset_i(reset_i), .rs1_i(rs1), .rs2_i(rs2),
		.rdata1_o(rdata1), .rdata2_o(rdata2), .wr_i(fwd_wb)
	);

	// load-use bubble goes in here
	pipe_reg #(.payload_t(id_ex_t), .bubble(id_ex_bubble)) u_id_ex (
		.clk_i(clk_i), .reset_i(reset_i), .hold_i(data_stall_i),
		.flush_i(!data_stall_i && (branch_taken || load_use_stall)),
		.d_i(id_ex_d), .q_o(id_ex_q)
	);

	execute_stage u_execute (
		.id_ex_i(id_ex_q), .fwd_mem_i(fwd_mem), .fwd_wb_i(fwd_wb),
		.branch_taken_o(branch_taken), .branch_target_o(branch_target),
		.data_addr_o(data_addr_o), .data_o(data_o), .data_req_o(data_req_o),
		.data_we_o(data_we_o), .ex_mem_o(ex_mem_d)
	);

	pipe_reg #(.payload_t(ex_mem_t), .bubble(ex_mem_bubble)) u_ex_mem (
		.clk_i(clk_i), .reset_i(reset_i), .hold_i(data_stall_i), .flush_i(1'b0),
		.d_i(ex_mem_d), .q_o(ex_mem_q)
	);

	assign fwd_mem = '{
		rd:        ex_mem_q.rd,
		reg_write: ex_mem_q.reg_write && !ex_mem_q.load, // load data not back yet
		value:     (ex_mem_q.wb_sel == wb_pc4) ? ex_mem_q.pc_plus4 : ex_mem_q.result
	};

	// read data is only valid the cycle after acceptance, keep it while frozen
	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
			mem_fresh_q <= 1'b0;
		else
			mem_fresh_q <= !data_stall_i;
	end

	always_ff @(posedge clk_i)
	begin
		if (mem_fresh_q)
			rdata_q <= data_i;
	end

	assign load_data = mem_fresh_q ? data_i : rdata_q;

	assign mem_wb_d = '{
		result:    ex_mem_q.result,
		load_data: load_data,
		pc_plus4:  ex_mem_q.pc_plus4,
		rd:        ex_mem_q.rd,
		reg_write: ex_mem_q.reg_write,
		wb_sel:    ex_mem_q.wb_sel
	};

	pipe_reg #(.payload_t(mem_wb_t), .bubble(mem_wb_bubble)) u_mem_wb (
		.clk_i(clk_i), .reset_i(reset_i), .hold_i(data_stall_i), .flush_i(1'b0),
		.d_i(mem_wb_d), .q_o(mem_wb_q)
	);

	writeback_stage u_writeback (
		.mem_wb_i(mem_wb_q), .fwd_wb_o(fwd_wb)
	);

endmodule

//--- writeback_stage.sv
`timescale 1ns/1ns

module writeback_stage (
	input  rv_pkg::mem_wb_t mem_wb_i,
	output rv_pkg::fwd_t    fwd_wb_o
);

	import rv_pkg::*;

	word_t wb_value;

	always_comb
	begin
		case (mem_wb_i.wb_sel)
			wb_load: wb_value = mem_wb_i.load_data;
			wb_pc4:  wb_value = mem_wb_i.pc_plus4; // jal/jalr link
			default: wb_value = mem_wb_i.result;
		endcase
	end

	// same record feeds the register file and the forwarding mux
	assign fwd_wb_o = '{
		rd:        mem_wb_i.rd,
		reg_write: mem_wb_i.reg_write,
		value:     wb_value
	};

endmodule

//--- execute_stage.sv
`timescale 1ns/1ns

module execute_stage (
	input  rv_pkg::id_ex_t  id_ex_i,
	input  rv_pkg::fwd_t    fwd_mem_i,
	input  rv_pkg::fwd_t    fwd_wb_i,
	output logic            branch_taken_o,
	output rv_pkg::word_t   branch_target_o,
	output rv_pkg::word_t   data_addr_o,
	output rv_pkg::word_t   data_o,
	output logic            data_req_o,
	output logic            data_we_o,
	output rv_pkg::ex_mem_t ex_mem_o
);

	import rv_pkg::*;

	word_t op_a, op_b;   // register operands after forwarding
	word_t src_a, src_b; // alu inputs
	word_t alu_res;
	word_t jump_base;
	word_t target_sum;

	// the younger result in mem wins over wb
	function automatic word_t fwd_sel(input reg_idx_t rs, input word_t rf_val,
			input fwd_t mem, input fwd_t wb);
		if (rs != '0 && mem.reg_write && mem.rd == rs)
			return mem.value;
		if (rs != '0 && wb.reg_write && wb.rd == rs)
			return wb.value;
		return rf_val;
	endfunction

	assign op_a = fwd_sel(id_ex_i.rs1, id_ex_i.rs1_val, fwd_mem_i, fwd_wb_i);
	assign op_b = fwd_sel(id_ex_i.rs2, id_ex_i.rs2_val, fwd_mem_i, fwd_wb_i);

	assign src_a = id_ex_i.a_is_pc ? id_ex_i.pc : op_a;
	assign src_b = id_ex_i.b_is_imm ? id_ex_i.imm : op_b;

	always_comb
	begin
		case (id_ex_i.alu_op)
			alu_add:  alu_res = src_a + src_b;
			alu_sub:  alu_res = src_a - src_b;
			alu_sll:  alu_res = src_a << src_b[4:0];
			alu_slt:  alu_res = word_t'($signed(src_a) < $signed(src_b));
			alu_sltu: alu_res = word_t'(src_a < src_b);
			alu_xor:  alu_res = src_a ^ src_b;
			alu_srl:  alu_res = src_a >> src_b[4:0];
			alu_sra:  alu_res = $signed(src_a) >>> src_b[4:0];
			alu_or:   alu_res = src_a | src_b;
			alu_and:  alu_res = src_a & src_b;
			alu_eq:   alu_res = word_t'(src_a == src_b);
			alu_ne:   alu_res = word_t'(src_a != src_b);
			alu_lt:   alu_res = word_t'($signed(src_a) < $signed(src_b));
			alu_ge:   alu_res = word_t'($signed(src_a) >= $signed(src_b));
			alu_ltu:  alu_res = word_t'(src_a < src_b);
			alu_geu:  alu_res = word_t'(src_a >= src_b);
			default:  alu_res = src_a + src_b;
		endcase
	end

	// branches and jal add to pc, jalr to rs1
	assign jump_base = id_ex_i.jalr ? op_a : id_ex_i.pc;
	assign target_sum = jump_base + id_ex_i.imm;
	assign branch_target_o = {target_sum[xlen-1:1], target_sum[0] & ~id_ex_i.jalr};
	assign branch_taken_o = id_ex_i.jump || (id_ex_i.branch && alu_res[0]);

	// loads and stores go out straight from ex
	assign data_req_o = id_ex_i.load || id_ex_i.store;
	assign data_we_o = id_ex_i.store;
	assign data_addr_o = alu_res;
	assign data_o = op_b;

	assign ex_mem_o = '{
		result:    alu_res,
		pc_plus4:  id_ex_i.pc + word_t'(4),
		rd:        id_ex_i.rd,
		reg_write: id_ex_i.reg_write,
		load:      id_ex_i.load,
		wb_sel:    id_ex_i.wb_sel
	};

endmodule

//--- decode_stage.sv
`timescale 1ns/1ns

module decode_stage (
	input  rv_pkg::if_id_t   if_id_i,
	input  rv_pkg::reg_idx_t ex_rd_i,
	input  logic             ex_load_i,
	input  rv_pkg::word_t    rdata1_i,
	input  rv_pkg::word_t    rdata2_i,
	output rv_pkg::reg_idx_t rs1_o,
	output rv_pkg::reg_idx_t rs2_o,
	output logic             load_use_stall_o,
	output rv_pkg::id_ex_t   id_ex_o
);

	import rv_pkg::*;

	word_t      instr;
	opcode_e    opcode;
	logic [2:0] funct3;
	logic       use_rs1;
	logic       use_rs2;
	word_t      imm_i, imm_s, imm_b, imm_u, imm_j;

	function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  return alt ? alu_sub : alu_add;
			3'b001:  return alu_sll;
			3'b010:  return alu_slt;
			3'b011:  return alu_sltu;
			3'b100:  return alu_xor;
			3'b101:  return alt ? alu_sra : alu_srl;
			3'b110:  return alu_or;
			default: return alu_and;
		endcase
	endfunction

	function automatic alu_op_e branch_op(input logic [2:0] f3);
		case (f3)
			3'b001:  return alu_ne;
			3'b100:  return alu_lt;
			3'b101:  return alu_ge;
			3'b110:  return alu_ltu;
			3'b111:  return alu_geu;
			default: return alu_eq;
		endcase
	endfunction

	assign instr = if_id_i.instr;
	assign opcode = opcode_e'(instr[6:0]);
	assign funct3 = instr[14:12];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

	// unused source fields become x0, so lui reads a zero operand a
	assign use_rs1 = !(opcode inside {opc_lui, opc_auipc, opc_jal});
	assign use_rs2 = opcode inside {opc_op, opc_branch, opc_store};
	assign rs1_o = use_rs1 ? instr[19:15] : '0;
	assign rs2_o = use_rs2 ? instr[24:20] : '0;

	assign load_use_stall_o = ex_load_i && ex_rd_i != '0
		&& (ex_rd_i == rs1_o || ex_rd_i == rs2_o);

	always_comb
	begin
		id_ex_o = id_ex_bubble; // unknown opcodes pass as a nop
		id_ex_o.pc = if_id_i.pc;
		id_ex_o.rs1_val = rdata1_i;
		id_ex_o.rs2_val = rdata2_i;
		id_ex_o.rs1 = rs1_o;
		id_ex_o.rs2 = rs2_o;
		id_ex_o.rd = instr[11:7];
		case (opcode)
			opc_op:
			begin
				id_ex_o.alu_op = arith_op(funct3, instr[30]);
				id_ex_o.reg_write = 1'b1;
			end
			opc_op_imm:
			begin
				id_ex_o.alu_op = arith_op(funct3, funct3 == 3'b101 && instr[30]); // srai only
				id_ex_o.b_is_imm = 1'b1;
				id_ex_o.imm = imm_i;
				id_ex_o.reg_write = 1'b1;
			end
			opc_lui, opc_auipc:
			begin
				id_ex_o.a_is_pc = (opcode == opc_auipc);
				id_ex_o.b_is_imm = 1'b1;
				id_ex_o.imm = imm_u;
				id_ex_o.reg_write = 1'b1;
			end
			opc_jal, opc_jalr:
			begin
				id_ex_o.jump = 1'b1;
				id_ex_o.jalr = (opcode == opc_jalr);
				id_ex_o.imm = (opcode == opc_jalr) ? imm_i : imm_j;
				id_ex_o.reg_write = 1'b1;
				id_ex_o.wb_sel = wb_pc4; // link value
			end
			opc_branch:
			begin
				id_ex_o.alu_op = branch_op(funct3);
				id_ex_o.branch = 1'b1;
				id_ex_o.imm = imm_b;
			end
			opc_load:
			begin
				id_ex_o.b_is_imm = 1'b1;
				id_ex_o.imm = imm_i;
				id_ex_o.load = 1'b1;
				id_ex_o.reg_write = 1'b1;
				id_ex_o.wb_sel = wb_load;
			end
			opc_store:
			begin
				id_ex_o.b_is_imm = 1'b1;
				id_ex_o.imm = imm_s;
				id_ex_o.store = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

//--- reg_file.sv
`timescale 1ns/1ns

module reg_file (
	input  logic             clk_i,
	input  logic             reset_i,
	input  rv_pkg::reg_idx_t rs1_i,
	input  rv_pkg::reg_idx_t rs2_i,
	output rv_pkg::word_t    rdata1_o,
	output rv_pkg::word_t    rdata2_o,
	input  rv_pkg::fwd_t     wr_i
);

	import rv_pkg::*;

	word_t regs [2**reg_addr_w];

	// falling edge write so decode sees it in the same cycle
	always_ff @(negedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
		begin
			for (int i = 0; i < 2**reg_addr_w; i++)
				regs[i] <= '0;
		end
		else if (wr_i.reg_write && wr_i.rd != '0)
			regs[wr_i.rd] <= wr_i.value;
	end

	assign rdata1_o = (rs1_i == '0) ? '0 : regs[rs1_i]; // x0 hardwired
	assign rdata2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

//--- fetch_stage.sv
`timescale 1ns/1ns

module fetch_stage (
	input  logic           clk_i,
	input  logic           reset_i,
	input  logic           hold_i,
	input  logic           branch_taken_i,
	input  rv_pkg::word_t  branch_target_i,
	input  rv_pkg::word_t  instr_i,
	output rv_pkg::word_t  instr_addr_o,
	output rv_pkg::if_id_t if_id_o
);

	import rv_pkg::*;

	word_t pc_q;          // address of the word now on instr_i
	logic  fetch_valid_q; // low until the first read after reset returns
	word_t next_pc;

	// a held pc is presented again so the memory repeats the same word
	always_comb
	begin
		if (!fetch_valid_q || hold_i)
			next_pc = pc_q;
		else if (branch_taken_i)
			next_pc = branch_target_i;
		else
			next_pc = pc_q + word_t'(4);
	end

	assign instr_addr_o = next_pc;

	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
		begin
			pc_q <= reset_vector;
			fetch_valid_q <= 1'b0;
		end
		else
		begin
			pc_q <= next_pc;
			fetch_valid_q <= 1'b1;
		end
	end

	assign if_id_o = fetch_valid_q ? if_id_t'{instr: instr_i, pc: pc_q} : if_id_bubble;

endmodule

//--- pipe_reg.sv
`timescale 1ns/1ns

module pipe_reg #(
	parameter type payload_t = logic [31:0],
	parameter payload_t bubble = '0
) (
	input  logic     clk_i,
	input  logic     reset_i,
	input  logic     hold_i,
	input  logic     flush_i,
	input  payload_t d_i,
	output payload_t q_o
);

	// flush wins over hold
	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
			q_o <= bubble;
		else if (flush_i)
			q_o <= bubble; // kill the stage contents
		else if (!hold_i)
			q_o <= d_i;
	end

endmodule

//--- rv_pkg.sv
package rv_pkg;

	localparam int xlen = 32;
	localparam int reg_addr_w = 5;

	typedef logic [xlen-1:0] word_t;
	typedef logic [reg_addr_w-1:0] reg_idx_t;

	localparam word_t reset_vector = '0;
	localparam word_t nop_instr = 32'h0000_0013; // addi x0, x0, 0

	// major opcodes kept from rv32i
	typedef enum logic [6:0] {
		opc_lui    = 7'b0110111,
		opc_auipc  = 7'b0010111,
		opc_jal    = 7'b1101111,
		opc_jalr   = 7'b1100111,
		opc_branch = 7'b1100011,
		opc_load   = 7'b0000011,
		opc_store  = 7'b0100011,
		opc_op_imm = 7'b0010011,
		opc_op     = 7'b0110011
	} opcode_e;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor, alu_srl, alu_sra,
		alu_or, alu_and,
		alu_eq, alu_ne, alu_lt, alu_ge, alu_ltu, alu_geu // branch compares
	} alu_op_e;

	typedef enum logic [1:0] {wb_alu, wb_load, wb_pc4} wb_sel_e;

	typedef struct packed {
		word_t instr;
		word_t pc;
	} if_id_t;

	typedef struct packed {
		word_t    pc;
		word_t    rs1_val;
		word_t    rs2_val;
		word_t    imm;
		reg_idx_t rs1;
		reg_idx_t rs2;
		reg_idx_t rd;
		alu_op_e  alu_op;
		logic     a_is_pc;   // operand a taken from pc
		logic     b_is_imm;  // operand b taken from imm
		logic     branch;
		logic     jump;      // jal and jalr
		logic     jalr;
		logic     load;
		logic     store;
		logic     reg_write;
		wb_sel_e  wb_sel;
	} id_ex_t;

	typedef struct packed {
		word_t    result;
		word_t    pc_plus4;
		reg_idx_t rd;
		logic     reg_write;
		logic     load;
		wb_sel_e  wb_sel;
	} ex_mem_t;

	typedef struct packed {
		word_t    result;
		word_t    load_data;
		word_t    pc_plus4;
		reg_idx_t rd;
		logic     reg_write;
		wb_sel_e  wb_sel;
	} mem_wb_t;

	// one register write as seen by forwarding and the register file
	typedef struct packed {
		reg_idx_t rd;
		logic     reg_write;
		word_t    value;
	} fwd_t;

	localparam if_id_t if_id_bubble = '{instr: nop_instr, pc: reset_vector};
	localparam id_ex_t id_ex_bubble = '{alu_op: alu_add, wb_sel: wb_alu, default: '0};
	localparam ex_mem_t ex_mem_bubble = '{wb_sel: wb_alu, default: '0};
	localparam mem_wb_t mem_wb_bubble = '{wb_sel: wb_alu, default: '0};

endpackage
